//--- src/lsu_op_pkg.sv
// core side types; data path fixed at 32 bits, no module may use more than ADDR_W_MAX address bits
package lsu_op_pkg;

  ////////////////////
  // widths
  ////////////////////

  parameter int unsigned ADDR_W_MAX = 32;  // widest address any module may take
  parameter int unsigned DATA_W     = 32;  // register width of the core

  ////////////////////
  // access size
  ////////////////////

  // same code as the core's data type field
  typedef enum logic [1:0] {
    lsu_word = 2'b00,
    lsu_half = 2'b01,
    lsu_byte = 2'b10
  } lsu_size_e;

  ////////////////////
  // request and response
  ////////////////////

  // one memory operation from execute
  typedef struct packed {
    logic                  we;        // set for a store
    lsu_size_e             size;      // byte, half or word
    logic                  sign_ext;  // only looked at for loads
    logic [ADDR_W_MAX-1:0] addr;      // byte address, may be misaligned
    logic [DATA_W-1:0]     wdata;     // store data, right aligned in the register
  } lsu_req_t;

  // one answer per accepted request
  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // extended load data, zero on a store
    logic              we;     // tells the core which kind of op finished
  } lsu_rsp_t;

endpackage

//--- src/lsu_bus_pkg.sv
// memory bus types; 32-bit bus with byte lanes, part addresses always word aligned
package lsu_bus_pkg;

  parameter int unsigned BUS_DW    = 32;          // bus data width
  parameter int unsigned BUS_LANES = BUS_DW / 8;  // one enable per byte

  typedef logic [BUS_LANES-1:0] lsu_be_t;

  // everything driven onto the bus for one req/gnt transaction
  typedef struct packed {
    logic [lsu_op_pkg::ADDR_W_MAX-1:0] addr;   // word aligned
    logic                              we;
    lsu_be_t                           be;
    logic [BUS_DW-1:0]                 wdata;  // already rotated into its lanes
  } lsu_part_t;

  // a whole operation once split into bus parts
  typedef struct packed {
    lsu_part_t             part0;     // always issued
    lsu_part_t             part1;     // only issued when two_part is set
    logic                  two_part;  // access crosses a word boundary
    lsu_op_pkg::lsu_size_e size;      // kept for load extension
    logic                  sign_ext;
    logic [1:0]            offset;    // byte offset of the original address
  } lsu_split_t;

endpackage

//--- src/lsu_access_split.sv
// holds one op at a time; ADDR_W from 3 to 32, part1 address wraps at the top of the space
module lsu_access_split #(
  parameter int unsigned ADDR_W = 32
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid_i,
  input  lsu_op_pkg::lsu_req_t    req_i,
  input  logic                    op_done_i,
  output logic                    req_ready_o,
  output logic                    op_valid_o,
  output lsu_bus_pkg::lsu_split_t op_o
);
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  logic                   held_q;     // an op sits in the register
  lsu_split_t             op_q;
  lsu_split_t             op_d;
  logic                   accept;
  logic [1:0]             offset;
  logic [ADDR_W-1:0]      word_addr;
  logic [ADDR_W-1:0]      next_addr;
  logic [BUS_LANES-1:0]   size_mask;
  logic [2*BUS_LANES-1:0] be_wide;    // enables over two words
  logic [BUS_DW-1:0]      wdata_rot;
  logic                   two_part;

  assign accept    = req_valid_i & req_ready_o;
  assign offset    = req_i.addr[1:0];
  assign word_addr = {req_i.addr[ADDR_W-1:2], 2'b00};
  assign next_addr = word_addr + ADDR_W'(4);  // following word for part1

  ////////////////////
  // byte enables
  ////////////////////

  always_comb
  begin
    case (req_i.size)
      lsu_word: size_mask = 4'b1111;
      lsu_half: size_mask = 4'b0011;
      default:  size_mask = 4'b0001;
    endcase
  end

  // lanes past lane 3 land in the upper half and belong to part1
  assign be_wide = {{BUS_LANES{1'b0}}, size_mask} << offset;

  // misaligned word, or a half that starts in the last lane
  assign two_part = ((req_i.size == lsu_word) && (offset != 2'd0)) ||
                    ((req_i.size == lsu_half) && (offset == 2'd3));

  ////////////////////
  // write data
  ////////////////////

  // rotate left so byte 0 of the register sits in lane "offset"
  always_comb
  begin
    case (offset)
      2'd1:    wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'd2:    wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'd3:    wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
      default: wdata_rot = req_i.wdata;
    endcase
  end

  always_comb
  begin
    op_d.part0.addr  = ADDR_W_MAX'(word_addr);
    op_d.part0.we    = req_i.we;
    op_d.part0.be    = be_wide[BUS_LANES-1:0];            // offset up to lane 3
    op_d.part0.wdata = wdata_rot;
    op_d.part1.addr  = ADDR_W_MAX'(next_addr);
    op_d.part1.we    = req_i.we;
    op_d.part1.be    = be_wide[2*BUS_LANES-1:BUS_LANES];  // wrapped lanes
    op_d.part1.wdata = wdata_rot;                         // same rotation serves both
    op_d.two_part    = two_part;
    op_d.size        = req_i.size;
    op_d.sign_ext    = req_i.sign_ext;
    op_d.offset      = offset;
  end

  ////////////////////
  // holding register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      held_q <= 1'b0;
    else if (accept)
      held_q <= 1'b1;
    else if (op_done_i)
      held_q <= 1'b0;  // freed by the last rvalid
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      op_q <= op_d;
  end

  assign req_ready_o = ~held_q;
  assign op_valid_o  = held_q;
  assign op_o        = op_q;

endmodule

//--- src/lsu_bus_sequencer.sv
// one transaction outstanding; op_i must stay stable until op_done_o, second part may follow rvalid
module lsu_bus_sequencer #(
  parameter int unsigned ADDR_W = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          op_valid_i,
  input  lsu_bus_pkg::lsu_split_t       op_i,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  output logic                          data_req_o,
  output logic [ADDR_W-1:0]             data_addr_o,
  output logic                          data_we_o,
  output lsu_bus_pkg::lsu_be_t          data_be_o,
  output logic [lsu_bus_pkg::BUS_DW-1:0] data_wdata_o,
  output logic                          op_done_o,
  output logic                          first_rvalid_o,
  output logic                          last_rvalid_o
);
  import lsu_bus_pkg::*;

  typedef enum logic [2:0] {
    s_idle,          // nothing on the bus
    s_wait_gnt,      // part0 requested, no grant yet
    s_wait_rvalid,   // part0 granted
    s_wait_gnt2,     // part1 requested, no grant yet
    s_wait_rvalid2   // part1 granted
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  lsu_part_t  cur_part;   // part on the bus this cycle
  logic       use_part1;

  ////////////////////
  // part select
  ////////////////////

  // part1 goes out from the first rvalid onward, so it is picked in s_wait_rvalid too
  assign use_part1 = (state_q == s_wait_gnt2) ||
                     (state_q == s_wait_rvalid2) ||
                     ((state_q == s_wait_rvalid) && op_i.two_part);

  assign cur_part = use_part1 ? op_i.part1 : op_i.part0;

  assign data_addr_o  = cur_part.addr[ADDR_W-1:0];  // low bits only
  assign data_we_o    = cur_part.we;
  assign data_be_o    = cur_part.be;
  assign data_wdata_o = cur_part.wdata;

  ////////////////////
  // FSM
  ////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    first_rvalid_o = 1'b0;
    last_rvalid_o  = 1'b0;

    case (state_q)
      s_idle:
      begin
        // held op goes out in the cycle op_valid rises
        if (op_valid_i)
        begin
          data_req_o = 1'b1;
          state_d    = data_gnt_i ? s_wait_rvalid : s_wait_gnt;
        end
      end

      s_wait_gnt:
      begin
        data_req_o = 1'b1;  // keep asking, payload stays put
        if (data_gnt_i)
          state_d = s_wait_rvalid;
      end

      s_wait_rvalid:
      begin
        if (data_rvalid_i)
        begin
          if (op_i.two_part)
          begin
            first_rvalid_o = 1'b1;  // load align keeps this word
            data_req_o     = 1'b1;  // part1 issued in the same cycle
            state_d        = data_gnt_i ? s_wait_rvalid2 : s_wait_gnt2;
          end
          else
          begin
            last_rvalid_o = 1'b1;
            state_d       = s_idle;
          end
        end
      end

      s_wait_gnt2:
      begin
        data_req_o = 1'b1;
        if (data_gnt_i)
          state_d = s_wait_rvalid2;
      end

      s_wait_rvalid2:
      begin
        if (data_rvalid_i)
        begin
          last_rvalid_o = 1'b1;  // second half in, op complete
          state_d       = s_idle;
        end
      end

      default:
      begin
        state_d = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= s_idle;
    else
      state_q <= state_d;
  end

  // the holding register is freed by the same rvalid that ends the op
  assign op_done_o = last_rvalid_o;

endmodule

//--- src/lsu_load_align.sv
// fields must stay stable from first to last rvalid; response lasts one cycle, no back-pressure
module lsu_load_align (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           first_rvalid_i,
  input  logic                           last_rvalid_i,
  input  logic [lsu_bus_pkg::BUS_DW-1:0] data_rdata_i,
  input  lsu_op_pkg::lsu_size_e          size_i,
  input  logic                           sign_ext_i,
  input  logic [1:0]                     offset_i,
  input  logic                           we_i,
  output logic                           rsp_valid_o,
  output lsu_op_pkg::lsu_rsp_t           rsp_o
);
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  logic [BUS_DW-1:0]   first_q;       // word from part0 of a split access
  logic                first_held_q;  // set between the two rvalids
  logic [BUS_DW-1:0]   low_word;
  logic [2*BUS_DW-1:0] window;        // two consecutive words
  logic [BUS_DW-1:0]   lanes;         // four bytes starting at the offset
  logic [DATA_W-1:0]   ext_data;
  logic                rsp_valid_q;
  lsu_rsp_t            rsp_q;

  ////////////////////
  // lane assembly
  ////////////////////

  // a single part access finds all its bytes in the current word
  assign low_word = first_held_q ? first_q : data_rdata_i;

  // higher lanes of the old word first, wrapped lanes from the new one after
  assign window = {data_rdata_i, low_word};
  assign lanes  = BUS_DW'(window >> {offset_i, 3'b000});

  ////////////////////
  // extension
  ////////////////////

  always_comb
  begin
    case (size_i)
      lsu_byte: ext_data = {{24{sign_ext_i & lanes[7]}}, lanes[7:0]};    // bit 7 is the sign
      lsu_half: ext_data = {{16{sign_ext_i & lanes[15]}}, lanes[15:0]};  // bit 15 is the sign
      default:  ext_data = lanes;                                        // word, nothing to extend
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_held_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= last_rvalid_i;  // one cycle after the closing rvalid
      if (first_rvalid_i)
        first_held_q <= 1'b1;
      else if (last_rvalid_i)
        first_held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (first_rvalid_i)
      first_q <= data_rdata_i;  // stores land here too, never read back
    if (last_rvalid_i)
    begin
      rsp_q.rdata <= we_i ? '0 : ext_data;  // store answers carry no data
      rsp_q.we    <= we_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- src/lsu_top.sv
// one op in flight; ADDR_W from 3 to 32, response must be taken in its cycle
module lsu_top #(
  parameter int unsigned ADDR_W = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // core request side
  input  logic                           req_valid_i,
  input  lsu_op_pkg::lsu_req_t           req_i,
  output logic                           req_ready_o,
  // core response side
  output logic                           rsp_valid_o,
  output lsu_op_pkg::lsu_rsp_t           rsp_o,
  // data memory bus
  output logic                           data_req_o,
  input  logic                           data_gnt_i,
  input  logic                           data_rvalid_i,
  output logic [ADDR_W-1:0]              data_addr_o,
  output logic                           data_we_o,
  output lsu_bus_pkg::lsu_be_t           data_be_o,
  output logic [lsu_bus_pkg::BUS_DW-1:0] data_wdata_o,
  input  logic [lsu_bus_pkg::BUS_DW-1:0] data_rdata_i
);
  import lsu_bus_pkg::*;

  logic       op_valid;
  lsu_split_t op;            // held op, stable until op_done
  logic       op_done;
  logic       first_rvalid;
  logic       last_rvalid;

  lsu_access_split #(
    .ADDR_W (ADDR_W)
  ) u_access_split (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .op_done_i   (op_done),
    .req_ready_o (req_ready_o),
    .op_valid_o  (op_valid),
    .op_o        (op)
  );

  lsu_bus_sequencer #(
    .ADDR_W (ADDR_W)
  ) u_bus_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid),
    .op_i           (op),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .op_done_o      (op_done),
    .first_rvalid_o (first_rvalid),
    .last_rvalid_o  (last_rvalid)
  );

  // op fields come straight from the holding register
  lsu_load_align u_load_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .first_rvalid_i (first_rvalid),
    .last_rvalid_i  (last_rvalid),
    .data_rdata_i   (data_rdata_i),
    .size_i         (op.size),
    .sign_ext_i     (op.sign_ext),
    .offset_i       (op.offset),
    .we_i           (op.part0.we),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

//--- test/lsu_mem_model.sv
// 256 byte bus slave, address bits above 7 ignored; one outstanding txn, memory filled by the testbench
module lsu_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o      // protocol violation seen
);
  logic [7:0]  mem [256];
  logic [1:0]  gnt_wait_q;       // cycles of req left before the next grant
  logic [1:0]  rv_wait_q;        // cycles left before rvalid
  logic        pend_q;           // granted, rvalid still to come
  logic        held_q;           // req last cycle without a grant
  logic [68:0] payload_q;
  logic [68:0] payload;          // addr, we, be, wdata
  logic [7:0]  base;
  string       err_msg;

  assign payload  = {addr_i, we_i, be_i, wdata_i};
  assign base     = {addr_i[7:2], 2'b00};
  assign rvalid_o = pend_q && (rv_wait_q == 2'd0);
  // a new grant may share the cycle with the rvalid that ends the previous txn
  assign gnt_o    = req_i && (gnt_wait_q == 2'd0) && (!pend_q || rvalid_o);

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gnt_wait_q <= 2'd0;
      rv_wait_q  <= 2'd0;
      pend_q     <= 1'b0;
      held_q     <= 1'b0;
      payload_q  <= '0;
      rdata_o    <= '0;
      err_o      <= 1'b0;
    end
    else
    begin
      ////////////////////
      // protocol checks
      assert (!held_q || req_i) else
      begin
        err_msg = "data_req_o dropped before its grant";
        err_o   <= 1'b1;
      end
      assert (!(held_q && req_i && (payload != payload_q))) else
      begin
        err_msg = $sformatf("mismatch data_addr_o/we/be/wdata: got 0x%h expected 0x%h",
                            payload, payload_q);
        err_o   <= 1'b1;
      end
      assert (!(req_i && pend_q && !rvalid_o)) else
      begin
        err_msg = "new bus request while a transaction is outstanding";
        err_o   <= 1'b1;
      end

      held_q    <= req_i && !gnt_o;
      payload_q <= payload;
      if (req_i && (gnt_wait_q != 2'd0))
        gnt_wait_q <= gnt_wait_q - 2'd1;  // delay only runs while asked

      if (gnt_o)
      begin
        gnt_wait_q <= 2'($urandom % 4);   // 0 to 3 cycles for the next grant
        rv_wait_q  <= 2'($urandom % 3);   // rvalid 1 to 3 cycles after grant
        pend_q     <= 1'b1;
        if (we_i)
        begin
          for (int l = 0; l < 4; l++)
            if (be_i[l])
              mem[base + 8'(l)] <= wdata_i[8*l +: 8];
        end
        else
          rdata_o <= {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
      end
      else if (rvalid_o)
        pend_q <= 1'b0;
      else if (pend_q)
        rv_wait_q <= rv_wait_q - 2'd1;
    end
  end

endmodule

//--- test/lsu_tb.sv
// test addresses stay below 0xf8 so both parts fit in the 256 byte memory model
module lsu_tb;
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  localparam int unsigned ADDR_W  = 32;
  localparam int          TIMEOUT = 50;  // cycles allowed for any one wait

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  lsu_req_t          req;
  logic              req_ready;
  logic              rsp_valid;
  lsu_rsp_t          rsp;
  logic              data_req;
  logic              data_gnt;
  logic              data_rvalid;
  logic [ADDR_W-1:0] data_addr;
  logic              data_we;
  lsu_be_t           data_be;
  logic [31:0]       data_wdata;
  logic [31:0]       data_rdata;
  logic              model_err;

  logic [7:0]        ref_mem [256];  // reference copy of the memory
  int                accept_cnt;
  int                rsp_cnt;
  logic [31:0]       txn_addr [$];   // granted bus parts of the current op
  lsu_be_t           txn_be [$];
  logic              txn_we [$];

  lsu_top #(.ADDR_W(ADDR_W)) uut (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata)
  );

  lsu_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req), .addr_i(data_addr), .we_i(data_we),
    .be_i(data_be), .wdata_i(data_wdata), .gnt_o(data_gnt), .rvalid_o(data_rvalid),
    .rdata_o(data_rdata), .err_o(model_err)
  );

  always #20 clk = ~clk;

  ////////////////////
  // monitors
  always @(posedge clk)
  begin
    if (req_valid && req_ready)
      accept_cnt++;
    if (rsp_valid)
      rsp_cnt++;
    if (data_req && data_gnt)
    begin
      txn_addr.push_back(data_addr);
      txn_be.push_back(data_be);
      txn_we.push_back(data_we);
    end
  end

  always @(posedge model_err)
    stop_run(u_mem.err_msg);

  task automatic stop_run(string line);
    $display("Testbench failed");
    $display("%s", line);
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else
      stop_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic int size_bytes(lsu_size_e size);
    case (size)
      lsu_byte: return 1;
      lsu_half: return 2;
      default:  return 4;
    endcase
  endfunction

  // lanes touched over two words, upper nibble is the second word
  function automatic logic [7:0] lanes_of(int off, int nbytes);
    logic [7:0] m;
    m = '0;
    for (int i = 0; i < nbytes; i++)
      m[off + i] = 1'b1;
    return m;
  endfunction

  ////////////////////
  // one operation
  task automatic run_op(logic we, lsu_size_e size, logic sx, logic [7:0] addr, logic [31:0] wdata);
    int          nb;
    int          n;
    int          parts;
    logic [7:0]  m;
    logic [7:0]  wbase;
    logic [31:0] exp;
    nb    = size_bytes(size);
    m     = lanes_of(int'(addr[1:0]), nb);
    parts = (m[7:4] != 4'd0) ? 2 : 1;
    wbase = {addr[7:2], 2'b00};
    n     = 0;
    while (!req_ready)
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT)
        stop_run("timeout waiting for req_ready_o");
    end
    txn_addr.delete();
    txn_be.delete();
    txn_we.delete();
    req.we       = we;
    req.size     = size;
    req.sign_ext = sx;
    req.addr     = 32'(addr);
    req.wdata    = wdata;
    req_valid    = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    exp = '0;
    for (int i = 0; i < nb; i++)  // little endian, byte i at addr + i
    begin
      if (we)
        ref_mem[addr + 8'(i)] = wdata[8*i +: 8];
      else
        exp[8*i +: 8] = ref_mem[addr + 8'(i)];
    end
    if (!we && sx && (nb < 4) && exp[8*nb-1])
      exp = exp | (32'hffff_ffff << (8*nb));  // copy the top kept bit upward
    n = 0;
    while (!rsp_valid)
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT)
        stop_run("timeout waiting for rsp_valid_o");
    end
    check_value("rsp_o.rdata", rsp.rdata, exp);
    check_value("rsp_o.we", 32'(rsp.we), 32'(we));
    check_value("bus transactions", 32'(txn_addr.size()), 32'(parts));
    check_value("data_addr_o part0", txn_addr[0], 32'(wbase));
    check_value("data_be_o part0", 32'(txn_be[0]), 32'(m[3:0]));
    check_value("data_we_o part0", 32'(txn_we[0]), 32'(we));
    if (parts == 2)
    begin
      check_value("data_addr_o part1", txn_addr[1], 32'(wbase + 8'd4));
      check_value("data_be_o part1", 32'(txn_be[1]), 32'(m[7:4]));
      check_value("data_we_o part1", 32'(txn_we[1]), 32'(we));
    end
    @(posedge clk);
    #1;
    check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);  // single cycle pulse
    check_value("response count", 32'(rsp_cnt), 32'(accept_cnt));
    if (we)
      for (int i = 0; i < 256; i++)  // neighbours must be untouched
        check_value($sformatf("mem[0x%h]", i), 32'(u_mem.mem[i]), 32'(ref_mem[i]));
  endtask

  ////////////////////
  // stimulus
  initial
  begin
    logic [7:0] a;
    void'($urandom(32));
    clk        = 1'b0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    accept_cnt = 0;
    rsp_cnt    = 0;
    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i]   = 8'(i * 37 + 91);  // odd step, every address bit matters
      u_mem.mem[i] = ref_mem[i];
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("data_req_o", 32'(data_req), 32'h0);
    check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);
    check_value("req_ready_o", 32'(req_ready), 32'h1);

    run_op(1'b1, lsu_word, 1'b0, 8'h40, $urandom);  // aligned round trip
    run_op(1'b0, lsu_word, 1'b0, 8'h40, 32'h0);

    // 0x80 row mostly positive bytes, 0xa0 row mostly negative
    for (int b = 0; b < 2; b++)
      for (int off = 0; off < 4; off++)
        for (int sx = 0; sx < 2; sx++)
        begin
          a = 8'h80 + 8'(32 * b + off);
          run_op(1'b0, lsu_byte, 1'(sx), a, 32'h0);
          run_op(1'b0, lsu_half, 1'(sx), a, 32'h0);
        end

    for (int off = 1; off < 4; off++)  // split word stores
    begin
      a = 8'h20 + 8'(9 * off);
      run_op(1'b1, lsu_word, 1'b0, a, $urandom);
      run_op(1'b0, lsu_word, 1'b0, a, 32'h0);
    end
    run_op(1'b1, lsu_half, 1'b0, 8'h47, $urandom);
    run_op(1'b0, lsu_half, 1'b1, 8'h47, 32'h0);
    run_op(1'b0, lsu_half, 1'b0, 8'h47, 32'h0);

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- lsu_top.f
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_access_split.sv
src/lsu_bus_sequencer.sv
src/lsu_load_align.sv
src/lsu_top.sv
test/lsu_mem_model.sv
test/lsu_tb.sv

//--- Makefile
# Verilator flow for the load/store unit testbench

VERILATOR ?= verilator
TB_TOP    ?= lsu_tb
FILELIST  ?= lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
